//--- compile.f
+incdir+verilog
verilog/mmu_pkg.sv
verilog/tlb_entry.sv
verilog/tlb_replace.sv
verilog/tlb_lookup.sv
verilog/page_walker.sv
verilog/mmu_sv32.sv
tests/tb_mmu_sv32.sv

//--- run_sim.sh
#!/bin/sh
# build and run the Sv32 MMU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -f compile.f \
    --top-module tb_mmu_sv32 -o sim_mmu_sv32
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_mmu_sv32)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- tests/tb_mmu_sv32.sv
`timescale 1ns/1ns
`default_nettype none

`include "mmu_consts.svh"

module tb_mmu_sv32;
    import mmu_pkg::*;

    // pte flag masks for the low byte of an entry
    localparam logic [7:0] F_V = 8'h01;
    localparam logic [7:0] F_R = 8'h02;
    localparam logic [7:0] F_W = 8'h04;
    localparam logic [7:0] F_U = 8'h10;
    localparam logic [7:0] F_A = 8'h40;
    localparam logic [7:0] F_D = 8'h80;
    localparam logic [7:0] SUP_RW = F_V | F_R | F_W | F_A | F_D;
    localparam ppn_t ROOT_PPN = 22'h00100;
    localparam ppn_t L0_PPN = 22'h00101;

    logic      clk_i;
    logic      rst_ni;
    logic      flush_tlb_i;
    logic      enable_translation_i;
    logic      sum_i;
    ppn_t      satp_ppn_i;
    logic      req_i;
    logic      is_store_i;
    vaddr_t    vaddr_i;
    priv_lvl_e priv_i;
    logic      ready_o;
    logic      valid_o;
    logic      fault_o;
    paddr_t    paddr_o;
    cause_t    cause_o;
    vaddr_t    tval_o;
    logic      cyc_o;
    logic      stb_o;
    paddr_t    adr_o;
    pte_t      dat_i;
    logic      ack_i;

    // page table words keyed by word address
    pte_t   pt_mem [logic [31:0]];
    integer seed = 16851;
    int     rd_count = 0;
    int     reads0;

    // expected results with the oldest first
    paddr_t exp_paddr_q [$];
    logic   exp_fault_q [$];
    cause_t exp_cause_q [$];
    vaddr_t exp_tval_q [$];

    mmu_sv32 u_mmu_sv32 (
        .clk_i (clk_i), .rst_ni (rst_ni), .flush_tlb_i (flush_tlb_i),
        .enable_translation_i (enable_translation_i), .sum_i (sum_i),
        .satp_ppn_i (satp_ppn_i), .req_i (req_i), .is_store_i (is_store_i),
        .vaddr_i (vaddr_i), .priv_i (priv_i), .ready_o (ready_o), .valid_o (valid_o),
        .fault_o (fault_o), .paddr_o (paddr_o), .cause_o (cause_o), .tval_o (tval_o),
        .cyc_o (cyc_o), .stb_o (stb_o), .adr_o (adr_o), .dat_i (dat_i), .ack_i (ack_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // --------------------
    // memory helpers
    // --------------------
    function automatic pte_t make_pte(input ppn_t ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    function automatic pte_t mem_read(input paddr_t a);
        // unmapped words read as an invalid entry
        if (pt_mem.exists(a[33:2])) begin
            return pt_mem[a[33:2]];
        end
        return '0;
    endfunction

    task automatic write_pte(input paddr_t a, input pte_t p);
        pt_mem[a[33:2]] = p;
    endtask

    // wishbone slave that acks after 0 to 3 idle cycles
    initial begin : wb_slave
        int wait_left;
        ack_i = 1'b0;
        dat_i = '0;
        wait_left = -1;
        forever begin
            @(negedge clk_i);
            if (ack_i) begin
                ack_i = 1'b0;
                wait_left = -1;
            end else if (cyc_o && stb_o) begin
                if (wait_left < 0) begin
                    wait_left = $unsigned($random(seed)) % 4;
                end
                if (wait_left == 0) begin
                    dat_i = mem_read(adr_o);
                    ack_i = 1'b1;
                end else begin
                    wait_left = wait_left - 1;
                end
            end
        end
    end

    // one count per completed bus read
    always @(posedge clk_i) begin
        if (cyc_o && stb_o && ack_i) begin
            rd_count <= rd_count + 1;
        end
    end

    // --------------------
    // reference model
    // --------------------
    function automatic void ref_translate(input vaddr_t va, input logic st,
                                          input priv_lvl_e pv, input logic sum,
                                          input logic en, output paddr_t pa,
                                          output logic flt, output cause_t cause);
        pte_t l1;
        pte_t leaf;
        logic mega;
        logic walk_bad;
        pa = {2'b00, va};
        flt = 1'b0;
        mega = 1'b0;
        leaf = '0;
        walk_bad = 1'b0;
        cause = st ? cause_t'(`MMU_CAUSE_ST_PF) : cause_t'(`MMU_CAUSE_LD_PF);
        if (en) begin
            l1 = mem_read({ROOT_PPN, va[31:22], 2'b00});
            if (!l1[0] || (l1[2] && !l1[1])) begin
                walk_bad = 1'b1;
            end else if (l1[1] || l1[3]) begin
                // a leaf at level 1 needs ppn[0] zero
                mega = 1'b1;
                leaf = l1;
                walk_bad = |l1[19:10];
            end else begin
                leaf = mem_read({l1[31:10], va[21:12], 2'b00});
                walk_bad = !leaf[0] || (leaf[2] && !leaf[1]) || !(leaf[1] || leaf[3]);
            end
            if (walk_bad) begin
                flt = 1'b1;
            end else begin
                flt = !leaf[6] || (st ? (!leaf[2] || !leaf[7]) : !leaf[1]);
                if (pv == PRIV_LVL_U) begin
                    flt = flt || !leaf[4];
                end else begin
                    flt = flt || (leaf[4] && !sum);
                end
                pa = mega ? {leaf[31:20], va[21:0]} : {leaf[31:10], va[11:0]};
            end
        end
    endfunction

    // --------------------
    // checks
    // --------------------
    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_paddr(input paddr_t got, input paddr_t exp);
        if (got !== exp) begin
            $display("FAILED paddr_o: got 0x%09h expected 0x%09h", got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_fault(input logic got_flt, input cause_t got_cause,
                               input vaddr_t got_tval, input logic exp_flt,
                               input cause_t exp_cause, input vaddr_t exp_tval);
        if (got_flt !== exp_flt) begin
            $display("FAILED fault_o: got 0x%0h expected 0x%0h", got_flt, exp_flt);
            stop_with_failure();
        end else if (exp_flt && got_cause !== exp_cause) begin
            $display("FAILED cause_o: got 0x%0h expected 0x%0h", got_cause, exp_cause);
            stop_with_failure();
        end else if (exp_flt && got_tval !== exp_tval) begin
            $display("FAILED tval_o: got 0x%08h expected 0x%08h", got_tval, exp_tval);
            stop_with_failure();
        end
    endtask

    task automatic check_reads(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("FAILED wishbone reads (%s): got 0x%0h expected 0x%0h", what, got, exp);
            stop_with_failure();
        end
    endtask

    // each result pulse against the oldest request
    always @(posedge clk_i) begin : compare_results
        if (rst_ni && valid_o) begin
            if (exp_fault_q.size() == 0) begin
                $display("valid_o pulsed with no request outstanding");
                stop_with_failure();
            end else begin
                check_fault(fault_o, cause_o, tval_o, exp_fault_q[0], exp_cause_q[0],
                            exp_tval_q[0]);
                if (!exp_fault_q[0]) begin
                    check_paddr(paddr_o, exp_paddr_q[0]);
                end
                void'(exp_paddr_q.pop_front());
                void'(exp_fault_q.pop_front());
                void'(exp_cause_q.pop_front());
                void'(exp_tval_q.pop_front());
            end
        end
    end

    // --------------------
    // stimulus tasks
    // --------------------
    task automatic send_req(input vaddr_t va, input logic st, input priv_lvl_e pv);
        paddr_t e_pa;
        logic   e_flt;
        cause_t e_cause;
        int     waited;
        logic   taken;
        ref_translate(va, st, pv, sum_i, enable_translation_i, e_pa, e_flt, e_cause);
        exp_paddr_q.push_back(e_pa);
        exp_fault_q.push_back(e_flt);
        exp_cause_q.push_back(e_cause);
        exp_tval_q.push_back(va);
        req_i = 1'b1;
        vaddr_i = va;
        is_store_i = st;
        priv_i = pv;
        waited = 0;
        taken = 1'b0;
        // held until an edge sees ready_o high
        while (!taken) begin
            @(posedge clk_i);
            taken = ready_o;
            waited++;
            if (!taken && waited > 200) begin
                $display("request for vaddr 0x%08h not accepted in 200 cycles", va);
                stop_with_failure();
            end
        end
        @(negedge clk_i);
        req_i = 1'b0;
    endtask

    task automatic wait_results_done();
        int waited;
        waited = 0;
        while (exp_fault_q.size() != 0) begin
            @(negedge clk_i);
            waited++;
            if (waited > 500) begin
                $display("results still missing after 500 cycles");
                stop_with_failure();
            end
        end
        @(negedge clk_i);
    endtask

    task automatic pulse_flush();
        flush_tlb_i = 1'b1;
        @(negedge clk_i);
        flush_tlb_i = 1'b0;
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial begin
        rst_ni = 1'b0;
        flush_tlb_i = 1'b0;
        enable_translation_i = 1'b0;
        sum_i = 1'b0;
        satp_ppn_i = ROOT_PPN;
        req_i = 1'b0;
        is_store_i = 1'b0;
        vaddr_i = '0;
        priv_i = PRIV_LVL_S;

        // root table holds a pointer, a megapage, a misaligned megapage and W without R
        write_pte({ROOT_PPN, 10'd1, 2'b00}, make_pte(L0_PPN, F_V));
        write_pte({ROOT_PPN, 10'd2, 2'b00}, make_pte(22'h3FC00, SUP_RW));
        write_pte({ROOT_PPN, 10'd3, 2'b00}, make_pte(22'h00401, SUP_RW));
        write_pte({ROOT_PPN, 10'd5, 2'b00}, make_pte(22'h00200, F_V | F_W));
        // level-0 table with vpn0 3 left invalid
        write_pte({L0_PPN, 10'd0, 2'b00}, make_pte(22'h2ABCD, SUP_RW));
        write_pte({L0_PPN, 10'd1, 2'b00}, make_pte(22'h2ABCE, F_V | F_R | F_A));
        write_pte({L0_PPN, 10'd2, 2'b00}, make_pte(22'h11111, SUP_RW | F_U));
        for (int i = 4; i < 8; i++) begin
            write_pte({L0_PPN, 10'(i), 2'b00}, make_pte(ppn_t'(22'h30000 + i), SUP_RW));
        end

        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        // bare mode makes no bus traffic
        reads0 = rd_count;
        send_req(32'h1234_5678, 1'b0, PRIV_LVL_S);
        send_req(32'hFFFF_FFFC, 1'b1, PRIV_LVL_U);
        wait_results_done();
        check_reads("bare mode", rd_count - reads0, 0);

        // 4K page walk and then hits back to back
        enable_translation_i = 1'b1;
        reads0 = rd_count;
        send_req(32'h0040_0123, 1'b0, PRIV_LVL_S);
        send_req(32'h0040_0FFC, 1'b1, PRIV_LVL_S);
        send_req(32'h0040_0008, 1'b0, PRIV_LVL_S);
        wait_results_done();
        check_reads("4K page", rd_count - reads0, 2);

        // megapage takes a single read
        reads0 = rd_count;
        send_req(32'h0080_5678, 1'b0, PRIV_LVL_S);
        send_req(32'h00BF_FFF0, 1'b1, PRIV_LVL_S);
        wait_results_done();
        check_reads("megapage", rd_count - reads0, 1);

        // permission faults
        send_req(32'h0040_1004, 1'b1, PRIV_LVL_S);
        send_req(32'h0040_0010, 1'b0, PRIV_LVL_U);
        send_req(32'h0040_2000, 1'b0, PRIV_LVL_S);
        wait_results_done();
        sum_i = 1'b1;
        send_req(32'h0040_2000, 1'b0, PRIV_LVL_S);
        wait_results_done();
        sum_i = 1'b0;
        send_req(32'h0040_2040, 1'b1, PRIV_LVL_U);

        // walk faults
        send_req(32'h0100_0000, 1'b0, PRIV_LVL_S);
        send_req(32'h00C0_0004, 1'b1, PRIV_LVL_S);
        send_req(32'h0040_3000, 1'b0, PRIV_LVL_S);
        send_req(32'h0140_0000, 1'b1, PRIV_LVL_S);
        wait_results_done();

        // cached page walks again after a flush
        pulse_flush();
        reads0 = rd_count;
        send_req(32'h0040_0123, 1'b0, PRIV_LVL_S);
        wait_results_done();
        check_reads("after flush", rd_count - reads0, 2);

        // five pages in four entries evict the first one
        pulse_flush();
        reads0 = rd_count;
        send_req(32'h0040_0000, 1'b0, PRIV_LVL_S);
        for (int i = 4; i < 8; i++) begin
            send_req(vaddr_t'(32'h0040_0000 + i * 32'h1000), 1'b0, PRIV_LVL_S);
        end
        wait_results_done();
        check_reads("five page fill", rd_count - reads0, 10);
        reads0 = rd_count;
        for (int i = 5; i < 8; i++) begin
            send_req(vaddr_t'(32'h0040_0000 + i * 32'h1000), 1'b1, PRIV_LVL_S);
        end
        send_req(32'h0040_4010, 1'b0, PRIV_LVL_S);
        wait_results_done();
        check_reads("surviving pages", rd_count - reads0, 0);
        reads0 = rd_count;
        send_req(32'h0040_0044, 1'b0, PRIV_LVL_S);
        wait_results_done();
        check_reads("evicted page", rd_count - reads0, 2);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/mmu_consts.svh
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// address geometry for Sv32 on a 34-bit physical bus
`define MMU_VLEN 32
`define MMU_PLEN 34
`define MMU_PPNW 22
`define MMU_VPNW 20
`define MMU_OFFW 12

// size of the fully associative data TLB
`define MMU_TLB_ENTRIES 4

// exception causes as defined by the privileged spec
`define MMU_CAUSE_LD_PF 13
`define MMU_CAUSE_ST_PF 15

// pte flag positions, G (bit 5) is not looked at
`define MMU_PTE_V 0
`define MMU_PTE_R 1
`define MMU_PTE_W 2
`define MMU_PTE_X 3
`define MMU_PTE_U 4
`define MMU_PTE_A 6
`define MMU_PTE_D 7
// ppn field starts here and runs to the msb
`define MMU_PTE_PPN_LSB 10

`endif

//--- verilog/mmu_pkg.sv
`default_nettype none

`include "mmu_consts.svh"

package mmu_pkg;

    // --------------------
    // address and pte vectors
    // --------------------
    typedef logic [`MMU_VLEN-1:0] vaddr_t;
    // also used as the wishbone byte address
    typedef logic [`MMU_PLEN-1:0] paddr_t;
    typedef logic [`MMU_PPNW-1:0] ppn_t;
    typedef logic [`MMU_VPNW-1:0] vpn_t;
    // raw entry as read from memory
    typedef logic [31:0] pte_t;
    typedef logic [3:0] cause_t;
    // one bit per TLB entry
    typedef logic [`MMU_TLB_ENTRIES-1:0] tlb_sel_t;

    // --------------------
    // state and privilege
    // --------------------
    typedef enum logic [2:0] {
        WALK_IDLE,
        WALK_L1_READ,
        WALK_L0_READ,
        WALK_REFILL,
        WALK_FAULT
    } walk_state_e;

    typedef enum logic {
        PRIV_LVL_U = 1'b0,
        PRIV_LVL_S = 1'b1
    } priv_lvl_e;

endpackage

`default_nettype wire

//--- verilog/mmu_sv32.sv
`timescale 1ns/1ns
`default_nettype none

`include "mmu_consts.svh"

module mmu_sv32 (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               flush_tlb_i,
    input  logic               enable_translation_i,
    input  logic               sum_i,
    input  mmu_pkg::ppn_t      satp_ppn_i,
    input  logic               req_i,
    input  logic               is_store_i,
    input  mmu_pkg::vaddr_t    vaddr_i,
    input  mmu_pkg::priv_lvl_e priv_i,
    output logic               ready_o,
    output logic               valid_o,
    output logic               fault_o,
    output mmu_pkg::paddr_t    paddr_o,
    output mmu_pkg::cause_t    cause_o,
    output mmu_pkg::vaddr_t    tval_o,
    output logic               cyc_o,
    output logic               stb_o,
    output mmu_pkg::paddr_t    adr_o,
    input  mmu_pkg::pte_t      dat_i,
    input  logic               ack_i
);
    import mmu_pkg::*;

    // request stage register
    logic      req_q;
    logic      is_store_q;
    vaddr_t    vaddr_q;
    priv_lvl_e priv_q;

    // TLB array and walker nets
    tlb_sel_t we;
    tlb_sel_t hit;
    tlb_sel_t is_4m;
    pte_t     pte [`MMU_TLB_ENTRIES];
    logic     refill;
    vpn_t     refill_vpn;
    pte_t     refill_pte;
    logic     refill_is_4m;
    logic     walk_fault;
    logic     lu_hit;
    logic     lu_miss;
    logic     perm_fault;
    paddr_t   lu_paddr;
    logic     translate;

    assign translate = req_q & enable_translation_i;
    // stall only while a translated request waits for its walk
    assign ready_o   = !translate || lu_hit || walk_fault;

    // --------------------
    // stage register
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q <= 1'b0;
        end else if (ready_o) begin
            req_q <= req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ready_o && req_i) begin
            vaddr_q    <= vaddr_i;
            is_store_q <= is_store_i;
            priv_q     <= priv_i;
        end
    end

    tlb_replace u_tlb_replace (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .refill_i (refill),
        .we_o     (we)
    );

    for (genvar i = 0; i < `MMU_TLB_ENTRIES; i++) begin : g_entry
        tlb_entry u_tlb_entry (
            .clk_i      (clk_i),
            .rst_ni     (rst_ni),
            .flush_i    (flush_tlb_i),
            .we_i       (we[i]),
            .wr_vpn_i   (refill_vpn),
            .wr_pte_i   (refill_pte),
            .wr_is_4m_i (refill_is_4m),
            .lu_vpn_i   (vaddr_q[`MMU_VLEN-1:`MMU_OFFW]),
            .hit_o      (hit[i]),
            .pte_o      (pte[i]),
            .is_4m_o    (is_4m[i])
        );
    end

    tlb_lookup u_tlb_lookup (
        .hit_i        (hit),
        .pte_i        (pte),
        .is_4m_i      (is_4m),
        .vaddr_i      (vaddr_q),
        .is_store_i   (is_store_q),
        .priv_i       (priv_q),
        .sum_i        (sum_i),
        .hit_o        (lu_hit),
        .miss_o       (lu_miss),
        .paddr_o      (lu_paddr),
        .perm_fault_o (perm_fault)
    );

    page_walker u_page_walker (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .start_i        (translate & lu_miss),
        .vaddr_i        (vaddr_q),
        .satp_ppn_i     (satp_ppn_i),
        .cyc_o          (cyc_o),
        .stb_o          (stb_o),
        .adr_o          (adr_o),
        .dat_i          (dat_i),
        .ack_i          (ack_i),
        .refill_o       (refill),
        .refill_vpn_o   (refill_vpn),
        .refill_pte_o   (refill_pte),
        .refill_is_4m_o (refill_is_4m),
        .walk_fault_o   (walk_fault)
    );

    // --------------------
    // result select
    // --------------------
    always_comb begin : result_sel
        valid_o = 1'b0;
        fault_o = 1'b0;
        // bare mode, zero extended
        paddr_o = paddr_t'(vaddr_q);
        if (req_q) begin
            if (!enable_translation_i) begin
                valid_o = 1'b1;
            end else if (lu_hit) begin
                valid_o = 1'b1;
                fault_o = perm_fault;
                paddr_o = lu_paddr;
            end else if (walk_fault) begin
                valid_o = 1'b1;
                fault_o = 1'b1;
            end
        end
    end

    // only page faults exist here, the access type picks the code
    assign cause_o = is_store_q ? cause_t'(`MMU_CAUSE_ST_PF) : cause_t'(`MMU_CAUSE_LD_PF);
    assign tval_o  = vaddr_q;

endmodule

`default_nettype wire

//--- verilog/page_walker.sv
`timescale 1ns/1ns
`default_nettype none

`include "mmu_consts.svh"

module page_walker (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            start_i,
    input  mmu_pkg::vaddr_t vaddr_i,
    input  mmu_pkg::ppn_t   satp_ppn_i,
    output logic            cyc_o,
    output logic            stb_o,
    output mmu_pkg::paddr_t adr_o,
    input  mmu_pkg::pte_t   dat_i,
    input  logic            ack_i,
    output logic            refill_o,
    output mmu_pkg::vpn_t   refill_vpn_o,
    output mmu_pkg::pte_t   refill_pte_o,
    output logic            refill_is_4m_o,
    output logic            walk_fault_o
);
    import mmu_pkg::*;

    walk_state_e state_q, state_d;
    logic        stb_q, stb_d;
    paddr_t      adr_q, adr_d;
    pte_t        pte_q, pte_d;
    logic        is_4m_q, is_4m_d;
    vpn_t        vpn;
    logic        rd_leaf;
    logic        rd_bad;

    // request stays stable in the stage register for the whole walk
    assign vpn = vaddr_i[`MMU_VLEN-1:`MMU_OFFW];

    // decode of the word on the bus
    assign rd_leaf = dat_i[`MMU_PTE_R] | dat_i[`MMU_PTE_X];
    // invalid, or the reserved W without R encoding
    assign rd_bad  = !dat_i[`MMU_PTE_V] | (dat_i[`MMU_PTE_W] & !dat_i[`MMU_PTE_R]);

    // --------------------
    // walk FSM
    // --------------------
    always_comb begin : walk_fsm
        state_d = state_q;
        stb_d   = stb_q;
        adr_d   = adr_q;
        pte_d   = pte_q;
        is_4m_d = is_4m_q;
        case (state_q)
            WALK_IDLE: begin
                if (start_i) begin
                    // root table entry at satp.ppn*4096 + vpn[1]*4
                    state_d = WALK_L1_READ;
                    stb_d   = 1'b1;
                    adr_d   = {satp_ppn_i, vpn[`MMU_VPNW-1:`MMU_VPNW/2], 2'b00};
                end
            end
            WALK_L1_READ: begin
                if (ack_i) begin
                    stb_d = 1'b0;
                    pte_d = dat_i;
                    if (rd_bad) begin
                        state_d = WALK_FAULT;
                    end else if (rd_leaf) begin
                        is_4m_d = 1'b1;
                        // megapage needs ppn[0] clear
                        if (|dat_i[`MMU_PTE_PPN_LSB +: `MMU_VPNW/2]) begin
                            state_d = WALK_FAULT;
                        end else begin
                            state_d = WALK_REFILL;
                        end
                    end else begin
                        // pointer to the next table
                        is_4m_d = 1'b0;
                        state_d = WALK_L0_READ;
                        adr_d   = {dat_i[`MMU_PTE_PPN_LSB +: `MMU_PPNW],
                                   vpn[`MMU_VPNW/2-1:0], 2'b00};
                    end
                end
            end
            WALK_L0_READ: begin
                if (!stb_q) begin
                    // one idle bus cycle between the two reads
                    stb_d = 1'b1;
                end else if (ack_i) begin
                    stb_d = 1'b0;
                    pte_d = dat_i;
                    // last level must be a valid leaf
                    if (rd_bad || !rd_leaf) begin
                        state_d = WALK_FAULT;
                    end else begin
                        state_d = WALK_REFILL;
                    end
                end
            end
            WALK_REFILL, WALK_FAULT: begin
                state_d = WALK_IDLE;
            end
            default: begin
                state_d = WALK_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= WALK_IDLE;
            stb_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            stb_q   <= stb_d;
        end
    end

    // address and fetched pte
    always_ff @(posedge clk_i) begin
        adr_q   <= adr_d;
        pte_q   <= pte_d;
        is_4m_q <= is_4m_d;
    end

    // --------------------
    // outputs
    // --------------------
    // read only master, cyc follows stb
    assign cyc_o          = stb_q;
    assign stb_o          = stb_q;
    assign adr_o          = adr_q;
    assign refill_o       = state_q == WALK_REFILL;
    assign refill_vpn_o   = vpn;
    assign refill_pte_o   = pte_q;
    assign refill_is_4m_o = is_4m_q;
    assign walk_fault_o   = state_q == WALK_FAULT;

    // classic handshake holds strobe and address until the slave acks
    a_wb_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (stb_o && !ack_i) |=> (stb_o && $stable(adr_o)));

endmodule

`default_nettype wire

//--- verilog/tlb_entry.sv
`timescale 1ns/1ns
`default_nettype none

`include "mmu_consts.svh"

module tlb_entry (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  logic          flush_i,
    input  logic          we_i,
    input  mmu_pkg::vpn_t wr_vpn_i,
    input  mmu_pkg::pte_t wr_pte_i,
    input  logic          wr_is_4m_i,
    input  mmu_pkg::vpn_t lu_vpn_i,
    output logic          hit_o,
    output mmu_pkg::pte_t pte_o,
    output logic          is_4m_o
);
    import mmu_pkg::*;

    logic valid_q;
    vpn_t tag_q;
    pte_t pte_q;
    logic is_4m_q;
    logic hi_match;
    logic lo_match;

    // valid bit cleared by reset and by a global flush
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (we_i) begin
            valid_q <= 1'b1;
        end
    end

    // tag and pte payload
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            tag_q   <= wr_vpn_i;
            pte_q   <= wr_pte_i;
            is_4m_q <= wr_is_4m_i;
        end
    end

    // vpn[1] always compared and vpn[0] ignored for a megapage
    assign hi_match = tag_q[`MMU_VPNW-1:`MMU_VPNW/2] == lu_vpn_i[`MMU_VPNW-1:`MMU_VPNW/2];
    assign lo_match = tag_q[`MMU_VPNW/2-1:0] == lu_vpn_i[`MMU_VPNW/2-1:0];
    assign hit_o    = valid_q && hi_match && (is_4m_q || lo_match);
    assign pte_o    = pte_q;
    assign is_4m_o  = is_4m_q;

    // flush is only issued with no walk in flight
    a_no_write_on_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |-> !we_i);

endmodule

`default_nettype wire

//--- verilog/tlb_lookup.sv
`timescale 1ns/1ns
`default_nettype none

`include "mmu_consts.svh"

module tlb_lookup (
    input  mmu_pkg::tlb_sel_t hit_i,
    input  mmu_pkg::pte_t     pte_i [`MMU_TLB_ENTRIES],
    input  mmu_pkg::tlb_sel_t is_4m_i,
    input  mmu_pkg::vaddr_t   vaddr_i,
    input  logic              is_store_i,
    input  mmu_pkg::priv_lvl_e priv_i,
    input  logic              sum_i,
    output logic              hit_o,
    output logic              miss_o,
    output mmu_pkg::paddr_t   paddr_o,
    output logic              perm_fault_o
);
    import mmu_pkg::*;

    pte_t sel_pte;
    logic sel_is_4m;
    ppn_t sel_ppn;

    // --------------------
    // entry select
    // --------------------
    // and-or mux, at most one entry hits
    always_comb begin : sel_entry
        sel_pte   = '0;
        sel_is_4m = 1'b0;
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            sel_pte   = sel_pte | ({32{hit_i[i]}} & pte_i[i]);
            sel_is_4m = sel_is_4m | (hit_i[i] & is_4m_i[i]);
        end
    end

    assign hit_o   = |hit_i;
    assign miss_o  = ~hit_o;
    assign sel_ppn = sel_pte[`MMU_PTE_PPN_LSB +: `MMU_PPNW];

    // --------------------
    // address forming
    // --------------------
    always_comb begin : form_paddr
        if (sel_is_4m) begin
            // megapage keeps vpn[0] and offset from the vaddr
            paddr_o = {sel_ppn[`MMU_PPNW-1:`MMU_VPNW/2],
                       vaddr_i[`MMU_OFFW+`MMU_VPNW/2-1:0]};
        end else begin
            paddr_o = {sel_ppn, vaddr_i[`MMU_OFFW-1:0]};
        end
    end

    // --------------------
    // permission check
    // --------------------
    always_comb begin : perm_check
        // accessed bit is never set by hardware here
        perm_fault_o = !sel_pte[`MMU_PTE_A];
        if (is_store_i) begin
            // store needs write permission and a dirty page
            perm_fault_o = perm_fault_o || !sel_pte[`MMU_PTE_W] || !sel_pte[`MMU_PTE_D];
        end else begin
            perm_fault_o = perm_fault_o || !sel_pte[`MMU_PTE_R];
        end
        if (priv_i == PRIV_LVL_U) begin
            // user may only touch user pages
            perm_fault_o = perm_fault_o || !sel_pte[`MMU_PTE_U];
        end else begin
            // supervisor reaches user pages only with SUM set
            perm_fault_o = perm_fault_o || (sel_pte[`MMU_PTE_U] && !sum_i);
        end
    end

    // duplicate tags would mean the walker refilled a page already cached
    always_comb begin : chk_hit
        assert ($onehot0(hit_i))
        else $error("tlb_lookup: more than one entry hits");
    end

endmodule

`default_nettype wire

//--- verilog/tlb_replace.sv
`timescale 1ns/1ns
`default_nettype none

`include "mmu_consts.svh"

module tlb_replace (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              refill_i,
    output mmu_pkg::tlb_sel_t we_o
);
    import mmu_pkg::*;

    // one-hot victim pointer where entry 0 goes first after reset
    tlb_sel_t victim_q;

    // --------------------
    // round-robin pointer
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            victim_q <= tlb_sel_t'(1);
        end else if (refill_i) begin
            // rotate one place per refill
            victim_q <= {victim_q[`MMU_TLB_ENTRIES-2:0], victim_q[`MMU_TLB_ENTRIES-1]};
        end
    end

    // write enable only while the walker pulses a refill
    assign we_o = refill_i ? victim_q : '0;

    // a refill must never land in two entries at once
    a_we_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(we_o));

endmodule

`default_nettype wire
